// ==== src.f ====
rtl/mipsPkg.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/regReadStage.sv
rtl/executeStage.sv
rtl/memStage.sv
rtl/mipsCore.sv
verif/mipsCoreTb.sv

// ==== Bender.yml ====
package:
  name: mipsCore

sources:
  - rtl/mipsPkg.sv
  - rtl/fetchStage.sv
  - rtl/decodeStage.sv
  - rtl/regReadStage.sv
  - rtl/executeStage.sv
  - rtl/memStage.sv
  - rtl/mipsCore.sv
  - target: simulation
    files:
      - verif/mipsCoreTb.sv

// ==== verif/mipsCoreTb.sv ====
`timescale 1ns/10ps

module mipsCoreTb;

	localparam int progLen    = 400;
	localparam int memWords   = 64;
	localparam int cycleLimit = progLen * 6 + 100;

	typedef struct packed {
		logic        isWrite;
		logic [31:0] addr;
		logic [1:0]  size;
		logic [31:0] data;
	} memEvent;

	logic                          CLK;
	logic                          rstN;
	logic [mipsPkg::dataWidth-1:0] instrAddress;
	mipsPkg::instrWord             instrData;
	logic [mipsPkg::dataWidth-1:0] dataAddress;
	logic                          memRead;
	logic                          memWrite;
	logic [mipsPkg::dataWidth-1:0] dataWrite;
	logic [1:0]                    writeSize;
	logic [mipsPkg::dataWidth-1:0] dataRead;

	mipsPkg::instrWord progMem [progLen];
	logic [31:0]       dataMem [memWords];  // memory answering the DUT
	logic [31:0]       modelMem [memWords];
	logic [31:0]       modelRegs [32];
	memEvent           expected [$];
	logic [31:0]       rngState;
	int                eventIdx;
	int                cycles;

	mipsCore u_mipsCore (
		.CLK(CLK), .rstN(rstN), .instrAddress(instrAddress), .instrData(instrData),
		.dataAddress(dataAddress), .memRead(memRead), .memWrite(memWrite),
		.dataWrite(dataWrite), .writeSize(writeSize), .dataRead(dataRead)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// ----------------------------------------
	// stimulus helpers
	// ----------------------------------------
	function automatic logic [31:0] nextRand();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	function automatic logic [4:0] randReg();
		return 5'(nextRand() % 8); // r0..r7 keeps hazards dense
	endfunction

	function automatic mipsPkg::instrWord encodeR(logic [5:0] fn, logic [4:0] rs,
			logic [4:0] rt, logic [4:0] rd, logic [4:0] shamt);
		mipsPkg::instrWord w;
		w.rType = '{mipsPkg::opSpecial, rs, rt, rd, shamt, fn};
		return w;
	endfunction

	function automatic mipsPkg::instrWord encodeI(logic [5:0] op, logic [4:0] rs,
			logic [4:0] rt, logic [15:0] imm);
		mipsPkg::instrWord w;
		w.iType = '{op, rs, rt, imm};
		return w;
	endfunction

	function automatic logic [5:0] aluFunct(logic [2:0] sel);
		case (sel)
			3'd0:    return mipsPkg::fnAddu;
			3'd1:    return mipsPkg::fnSubu;
			3'd2:    return mipsPkg::fnAnd;
			3'd3:    return mipsPkg::fnOr;
			3'd4:    return mipsPkg::fnXor;
			3'd5:    return mipsPkg::fnSlt;
			3'd6:    return mipsPkg::fnSll;
			default: return mipsPkg::fnSrl;
		endcase
	endfunction

	function automatic logic [31:0] fillWord(int idx);
		return 32'h9e37_79b9 * (idx + 1) ^ {idx[7:0], 24'h5a_c3_0f};
	endfunction

	// byte lanes follow the low address bits
	function automatic logic [31:0] mergeStore(logic [31:0] old, logic [31:0] addr,
			logic [1:0] size, logic [31:0] data);
		logic [31:0] w;
		w = old;
		if (size == mipsPkg::sizeByte) begin
			w[addr[1:0]*8 +: 8] = data[7:0];
		end else if (size == mipsPkg::sizeHalf) begin
			w[addr[1]*16 +: 16] = data[15:0];
		end else begin
			w = data;
		end
		return w;
	endfunction

	function automatic logic [31:0] sizeMask(logic [1:0] size);
		if (size == mipsPkg::sizeByte) return 32'h0000_00ff;
		else if (size == mipsPkg::sizeHalf) return 32'h0000_ffff;
		else return 32'hffff_ffff;
	endfunction

	function automatic mipsPkg::instrWord fetchWord(logic [31:0] addr);
		if (addr[31:2] < progLen) return progMem[addr[31:2]];
		else return '0; // past the program reads as zero
	endfunction

	task automatic buildProgram();
		logic [31:0] r;
		logic [31:0] r2;
		logic [5:0]  fn;
		logic [5:0]  op;
		int          kind;
		int          n;
		n = 0;
		for (int k = 1; k < 8; k++) begin   // give r1..r7 known values
			r = nextRand();
			progMem[n] = encodeI(mipsPkg::opAddiu, 5'd0, 5'(k), r[15:0]);
			n++;
		end
		while (n < progLen - 15) begin
			r    = nextRand();
			r2   = nextRand();
			kind = r2 % 16;
			if (kind < 6) begin
				fn = aluFunct(r[2:0]);
				progMem[n] = encodeR(fn, randReg(), randReg(), randReg(),
					(fn == mipsPkg::fnSll || fn == mipsPkg::fnSrl) ? r[8:4] : 5'd0);
			end else if (kind < 10) begin
				case (r[5:4])
					2'd0:    op = mipsPkg::opAddiu;
					2'd1:    op = mipsPkg::opAndi;
					2'd2:    op = mipsPkg::opOri;
					default: op = mipsPkg::opLui;
				endcase
				progMem[n] = encodeI(op, randReg(), randReg(), r[31:16]);
			end else if (kind < 12) begin
				progMem[n] = encodeI(mipsPkg::opLw, 5'd0, randReg(), {8'h00, r[13:8], 2'b00});
			end else if (kind == 12) begin
				progMem[n] = encodeI(mipsPkg::opSw, 5'd0, randReg(), {8'h00, r[13:8], 2'b00});
			end else if (kind == 13) begin
				progMem[n] = encodeI(mipsPkg::opSh, 5'd0, randReg(), {8'h00, r[14:8], 1'b0});
			end else if (kind == 14) begin
				progMem[n] = encodeI(mipsPkg::opSb, 5'd0, randReg(), {8'h00, r[15:8]});
			end else begin
				progMem[n] = {3'b110, r[2:0], r2[31:6]}; // opcodes 0x30..0x37 are unknown
			end
			n++;
		end
		for (int k = 1; k < 8; k++) begin   // final dump of r1..r7
			progMem[n] = encodeI(mipsPkg::opSw, 5'd0, 5'(k), 16'(k * 4));
			n++;
		end
		while (n < progLen) begin
			progMem[n] = '0;
			n++;
		end
	endtask

	// ----------------------------------------
	// reference model stepping one instruction at a time
	// ----------------------------------------
	task automatic runModel();
		mipsPkg::instrWord w;
		logic [31:0]       a;
		logic [31:0]       b;
		logic [31:0]       immS;
		logic [31:0]       immZ;
		logic [31:0]       addr;
		logic [31:0]       res;
		logic [4:0]        dst;
		logic              wr;
		memEvent           ev;
		for (int i = 0; i < progLen; i++) begin
			w    = progMem[i];
			a    = modelRegs[w.iType.rs];
			b    = modelRegs[w.iType.rt];
			immS = {{16{w.iType.imm[15]}}, w.iType.imm};
			immZ = {16'h0000, w.iType.imm};
			addr = a + immS;
			dst  = w.iType.rt;
			wr   = 1'b1;
			res  = '0;
			case (w.iType.opcode)
				mipsPkg::opSpecial: begin
					dst = w.rType.rd;
					case (w.rType.funct)
						mipsPkg::fnAddu: res = a + b;
						mipsPkg::fnSubu: res = a - b;
						mipsPkg::fnAnd:  res = a & b;
						mipsPkg::fnOr:   res = a | b;
						mipsPkg::fnXor:  res = a ^ b;
						mipsPkg::fnSlt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						mipsPkg::fnSll:  res = b << w.rType.shamt;
						mipsPkg::fnSrl:  res = b >> w.rType.shamt;
						default:         wr = 1'b0;
					endcase
				end
				mipsPkg::opAddiu: res = a + immS;
				mipsPkg::opAndi:  res = a & immZ;
				mipsPkg::opOri:   res = a | immZ;
				mipsPkg::opLui:   res = {w.iType.imm, 16'h0000};
				mipsPkg::opLw: begin
					res = modelMem[addr[7:2]];
					ev  = '{1'b0, addr, mipsPkg::sizeWord, 32'h0};
					expected.push_back(ev);
				end
				mipsPkg::opSw, mipsPkg::opSh, mipsPkg::opSb: begin
					wr = 1'b0;
					ev = '{1'b1, addr, mipsPkg::sizeWord, b};
					if (w.iType.opcode == mipsPkg::opSh) ev.size = mipsPkg::sizeHalf;
					if (w.iType.opcode == mipsPkg::opSb) ev.size = mipsPkg::sizeByte;
					expected.push_back(ev);
					modelMem[addr[7:2]] = mergeStore(modelMem[addr[7:2]], addr, ev.size, b);
				end
				default: wr = 1'b0;
			endcase
			if (wr && dst != 5'd0) modelRegs[dst] = res;
		end
	endtask

	// ----------------------------------------
	// checks
	// ----------------------------------------
	task automatic stopWithFail();
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic compareWord(string name, logic [mipsPkg::dataWidth-1:0] exp,
			logic [mipsPkg::dataWidth-1:0] act);
		if (exp !== act) begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
			stopWithFail();
		end
	endtask

	task automatic compareSize(string name, logic [1:0] exp, logic [1:0] act);
		if (exp !== act) begin
			$display("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act);
			stopWithFail();
		end
	endtask

	task automatic compareBit(string name, logic exp, logic act);
		if (exp !== act) begin
			$display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
			stopWithFail();
		end
	endtask

	task automatic matchEvent();
		memEvent ev;
		ev = expected[eventIdx];
		if (memRead && memWrite) begin
			$display("memRead and memWrite were both high at %0t", $time);
			stopWithFail();
		end else if (memWrite !== ev.isWrite) begin
			$display("at %0t memory event %0d came as the wrong kind of access",
				$time, eventIdx);
			stopWithFail();
		end else begin
			compareWord("dataAddress", ev.addr, dataAddress);
			if (ev.isWrite) begin
				compareSize("writeSize", ev.size, writeSize);
				compareWord("dataWrite", ev.data & sizeMask(ev.size),
					dataWrite & sizeMask(ev.size));
			end
			eventIdx++;
		end
	endtask

	// memories answer on the falling edge
	task automatic serviceCycle();
		if (memRead || memWrite) matchEvent();
		instrData = fetchWord(instrAddress);
		if (memRead) dataRead = dataMem[dataAddress[7:2]];
		if (memWrite) begin
			dataMem[dataAddress[7:2]] = mergeStore(dataMem[dataAddress[7:2]],
				dataAddress, writeSize, dataWrite);
		end
	endtask

	initial begin
		rstN      = 1'b0;
		instrData = '0;
		dataRead  = '0;
		rngState  = 32'd61722;
		eventIdx  = 0;
		cycles    = 0;
		for (int i = 0; i < 32; i++) modelRegs[i] = '0;
		for (int i = 0; i < memWords; i++) begin
			dataMem[i]  = fillWord(i);
			modelMem[i] = fillWord(i);
		end
		buildProgram();
		runModel();
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		compareBit("memRead", 1'b0, memRead);
		compareBit("memWrite", 1'b0, memWrite);
		compareWord("instrAddress", '0, instrAddress);
		rstN = 1'b1;
		serviceCycle();
		while (eventIdx < expected.size()) begin
			@(negedge CLK);
			cycles++;
			if (cycles > cycleLimit) begin
				$display("timeout after %0d cycles with %0d of %0d memory events seen",
					cycles, eventIdx, expected.size());
				stopWithFail();
			end else begin
				serviceCycle();
			end
		end
		$display("** PASS **");
		$finish;
	end

endmodule

// ==== rtl/mipsCore.sv ====
`timescale 1ns/10ps

module mipsCore (
	input  logic                          CLK,
	input  logic                          rstN,
	output logic [mipsPkg::dataWidth-1:0] instrAddress,
	input  mipsPkg::instrWord             instrData,
	output logic [mipsPkg::dataWidth-1:0] dataAddress,
	output logic                          memRead,
	output logic                          memWrite,
	output logic [mipsPkg::dataWidth-1:0] dataWrite,
	output logic [1:0]                    writeSize,
	input  logic [mipsPkg::dataWidth-1:0] dataRead
);

	// stage packets, each one registered in its driver
	mipsPkg::fetchPkt   fetchPkt;
	mipsPkg::ctrlPkt    ctrlPkt;
	mipsPkg::operandPkt operandPkt;
	mipsPkg::execPkt    execPkt;
	mipsPkg::wbPkt      wbPkt;
	logic               stall;   // hazard stall, holds fetch and decode

	fetchStage u_fetchStage (
		.CLK(CLK), .rstN(rstN), .stall(stall),
		.instrAddress(instrAddress), .instrData(instrData), .fetchOut(fetchPkt)
	);

	decodeStage u_decodeStage (
		.CLK(CLK), .rstN(rstN), .stall(stall),
		.fetchIn(fetchPkt), .ctrlOut(ctrlPkt)
	);

	regReadStage u_regReadStage (
		.CLK(CLK), .rstN(rstN), .ctrlIn(ctrlPkt), .wbIn(wbPkt),
		.stall(stall), .operandOut(operandPkt)
	);

	executeStage u_executeStage (
		.CLK(CLK), .rstN(rstN), .operandIn(operandPkt), .execOut(execPkt)
	);

	// ----------------------------------------
	// memory and writeback
	// ----------------------------------------
	memStage u_memStage (
		.CLK(CLK), .rstN(rstN), .execIn(execPkt),
		.dataAddress(dataAddress), .memRead(memRead), .memWrite(memWrite),
		.dataWrite(dataWrite), .writeSize(writeSize), .dataRead(dataRead),
		.wbOut(wbPkt)
	);

endmodule

// ==== rtl/memStage.sv ====
`timescale 1ns/10ps

module memStage (
	input  logic                          CLK,
	input  logic                          rstN,
	input  mipsPkg::execPkt               execIn,
	output logic [mipsPkg::dataWidth-1:0] dataAddress,
	output logic                          memRead,
	output logic                          memWrite,
	output logic [mipsPkg::dataWidth-1:0] dataWrite,
	output logic [1:0]                    writeSize,
	input  logic [mipsPkg::dataWidth-1:0] dataRead,
	output mipsPkg::wbPkt                 wbOut
);

	logic [mipsPkg::dataWidth-1:0] wbData;
	logic                          wbValid;

	// ----------------------------------------
	// data memory strobes
	// ----------------------------------------
	// one strobe per memory instruction, the packet stays only one cycle
	assign memRead     = execIn.valid & execIn.memRead;
	assign memWrite    = execIn.valid & execIn.memWrite;
	assign dataAddress = execIn.result;
	assign dataWrite   = execIn.storeData;   // memory keeps the low bytes
	assign writeSize   = execIn.writeSize;

	// lw returns the whole word, everything else takes the alu value
	assign wbData  = execIn.memRead ? dataRead : execIn.result;
	assign wbValid = execIn.valid & execIn.regWrite & (execIn.dest != '0);

	// ----------------------------------------
	// writeback register
	// ----------------------------------------
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			wbOut <= '0;
		end else begin
			wbOut.valid <= wbValid;
			wbOut.dest  <= execIn.dest;
			wbOut.data  <= wbData;
		end
	end

endmodule

// ==== rtl/executeStage.sv ====
`timescale 1ns/10ps

module executeStage (
	input  logic               CLK,
	input  logic               rstN,
	input  mipsPkg::operandPkt operandIn,
	output mipsPkg::execPkt    execOut
);

	logic [mipsPkg::dataWidth-1:0] srcA;
	logic [mipsPkg::dataWidth-1:0] srcB;
	logic [mipsPkg::dataWidth-1:0] aluValue;
	logic                          lessThan;

	assign srcA     = operandIn.operandA;
	assign srcB     = operandIn.useImm ? operandIn.immediate : operandIn.operandB;
	assign lessThan = $signed(srcA) < $signed(srcB);

	// ----------------------------------------
	// alu and shifter
	// ----------------------------------------
	always_comb begin
		case (operandIn.aluCtrl)
			mipsPkg::aluAdd: aluValue = srcA + srcB;
			mipsPkg::aluSub: aluValue = srcA - srcB;
			mipsPkg::aluAnd: aluValue = srcA & srcB;
			mipsPkg::aluOr:  aluValue = srcA | srcB;
			mipsPkg::aluXor: aluValue = srcA ^ srcB;
			mipsPkg::aluSlt: aluValue = {{(mipsPkg::dataWidth-1){1'b0}}, lessThan};
			mipsPkg::aluSll: aluValue = srcB << operandIn.shamt; // shifts act on rt
			mipsPkg::aluSrl: aluValue = srcB >> operandIn.shamt;
			mipsPkg::aluLui: aluValue = srcB;
			default:         aluValue = '0;
		endcase
	end

	// loads and stores form base plus sign-extended offset through the alu add
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			execOut <= '0;
		end else begin
			execOut.valid     <= operandIn.valid;
			execOut.dest      <= operandIn.dest;
			execOut.regWrite  <= operandIn.regWrite;
			execOut.memRead   <= operandIn.memRead;
			execOut.memWrite  <= operandIn.memWrite;
			execOut.writeSize <= operandIn.writeSize;
			execOut.result    <= aluValue;
			execOut.storeData <= operandIn.operandB; // rt value for stores
		end
	end

endmodule

// ==== rtl/regReadStage.sv ====
`timescale 1ns/10ps

module regReadStage (
	input  logic               CLK,
	input  logic               rstN,
	input  mipsPkg::ctrlPkt    ctrlIn,
	input  mipsPkg::wbPkt      wbIn,
	output logic               stall,
	output mipsPkg::operandPkt operandOut
);

	logic [mipsPkg::dataWidth-1:0] regFile [mipsPkg::regCount];
	logic [mipsPkg::regCount-1:0]  pending;      // one bit per register in flight
	logic [mipsPkg::dataWidth-1:0] rsVal;
	logic [mipsPkg::dataWidth-1:0] rtVal;
	logic                          srcBusy;
	logic                          destBusy;
	logic                          issue;
	logic                          claim;

	// ----------------------------------------
	// register file
	// ----------------------------------------
	always_ff @(posedge CLK) begin
		if (wbIn.valid) begin
			regFile[wbIn.dest] <= wbIn.data; // dest is never 0 here
		end
	end

	assign rsVal = (ctrlIn.rs == '0) ? '0 : regFile[ctrlIn.rs];
	assign rtVal = (ctrlIn.rt == '0) ? '0 : regFile[ctrlIn.rt];

	// ----------------------------------------
	// scoreboard and hazard stall
	// ----------------------------------------
	assign srcBusy  = pending[ctrlIn.rs] | pending[ctrlIn.rt];
	assign destBusy = ctrlIn.regWrite & pending[ctrlIn.dest];
	assign stall    = ctrlIn.valid & (srcBusy | destBusy);
	assign issue    = ctrlIn.valid & ~stall;

	// register 0 is never claimed, so it never stalls
	assign claim = issue & ctrlIn.regWrite & (ctrlIn.dest != '0);

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			pending <= '0;
		end else begin
			if (wbIn.valid) begin
				pending[wbIn.dest] <= 1'b0;
			end
			if (claim) begin
				pending[ctrlIn.dest] <= 1'b1; // set wins over a same-cycle clear
			end
		end
	end

	// ----------------------------------------
	// operand register toward execute
	// ----------------------------------------
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			operandOut <= '0;
		end else begin
			operandOut.valid     <= issue;  // bubble while stalled
			operandOut.dest      <= ctrlIn.dest;
			operandOut.regWrite  <= ctrlIn.regWrite;
			operandOut.aluCtrl   <= ctrlIn.aluCtrl;
			operandOut.useImm    <= ctrlIn.useImm;
			operandOut.immediate <= ctrlIn.immediate;
			operandOut.shamt     <= ctrlIn.shamt;
			operandOut.memRead   <= ctrlIn.memRead;
			operandOut.memWrite  <= ctrlIn.memWrite;
			operandOut.writeSize <= ctrlIn.writeSize;
			operandOut.operandA  <= rsVal;
			operandOut.operandB  <= rtVal;
		end
	end

endmodule

// ==== rtl/decodeStage.sv ====
`timescale 1ns/10ps

module decodeStage (
	input  logic             CLK,
	input  logic             rstN,
	input  logic             stall,
	input  mipsPkg::fetchPkt fetchIn,
	output mipsPkg::ctrlPkt  ctrlOut
);

	mipsPkg::instrWord             instr;
	mipsPkg::ctrlPkt               dec;
	logic [15:0]                   imm;
	logic [mipsPkg::dataWidth-1:0] immSign;
	logic [mipsPkg::dataWidth-1:0] immZero;
	logic [mipsPkg::dataWidth-1:0] immUpper;

	assign instr    = fetchIn.instr;
	assign imm      = instr.iType.imm;
	assign immSign  = {{16{imm[15]}}, imm};
	assign immZero  = {16'h0000, imm};
	assign immUpper = {imm, 16'h0000};  // lui

	// ----------------------------------------
	// decoder
	// ----------------------------------------
	always_comb begin
		dec           = '0;
		dec.valid     = fetchIn.valid;
		dec.aluCtrl   = mipsPkg::aluAdd;
		dec.writeSize = mipsPkg::sizeWord;
		dec.rs        = instr.iType.rs;
		dec.rt        = instr.iType.rt;
		dec.dest      = instr.iType.rt; // I-type writes rt
		case (instr.iType.opcode)
			mipsPkg::opSpecial: begin
				dec.dest     = instr.rType.rd;
				dec.shamt    = instr.rType.shamt;
				dec.regWrite = 1'b1;
				case (instr.rType.funct)
					mipsPkg::fnAddu: dec.aluCtrl = mipsPkg::aluAdd;
					mipsPkg::fnSubu: dec.aluCtrl = mipsPkg::aluSub;
					mipsPkg::fnAnd:  dec.aluCtrl = mipsPkg::aluAnd;
					mipsPkg::fnOr:   dec.aluCtrl = mipsPkg::aluOr;
					mipsPkg::fnXor:  dec.aluCtrl = mipsPkg::aluXor;
					mipsPkg::fnSlt:  dec.aluCtrl = mipsPkg::aluSlt;
					mipsPkg::fnSll:  dec.aluCtrl = mipsPkg::aluSll;
					mipsPkg::fnSrl:  dec.aluCtrl = mipsPkg::aluSrl;
					default:         dec.regWrite = 1'b0; // retires as a no-op
				endcase
			end
			mipsPkg::opAddiu: begin
				dec.regWrite  = 1'b1;
				dec.useImm    = 1'b1;
				dec.immediate = immSign;
			end
			mipsPkg::opAndi: begin
				dec.regWrite  = 1'b1;
				dec.useImm    = 1'b1;
				dec.aluCtrl   = mipsPkg::aluAnd;
				dec.immediate = immZero;
			end
			mipsPkg::opOri: begin
				dec.regWrite  = 1'b1;
				dec.useImm    = 1'b1;
				dec.aluCtrl   = mipsPkg::aluOr;
				dec.immediate = immZero;
			end
			mipsPkg::opLui: begin
				dec.regWrite  = 1'b1;
				dec.useImm    = 1'b1;
				dec.aluCtrl   = mipsPkg::aluLui;
				dec.immediate = immUpper;
			end
			mipsPkg::opLw: begin
				dec.regWrite  = 1'b1;
				dec.memRead   = 1'b1;
				dec.useImm    = 1'b1;
				dec.immediate = immSign;
			end
			mipsPkg::opSw, mipsPkg::opSh, mipsPkg::opSb: begin
				dec.memWrite  = 1'b1;
				dec.useImm    = 1'b1;
				dec.immediate = immSign;
				if (instr.iType.opcode == mipsPkg::opSh) begin
					dec.writeSize = mipsPkg::sizeHalf;
				end else if (instr.iType.opcode == mipsPkg::opSb) begin
					dec.writeSize = mipsPkg::sizeByte;
				end
			end
			default: ; // nothing written for an unknown opcode
		endcase
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			ctrlOut <= '0;
		end else if (!stall) begin
			ctrlOut <= dec;
		end
	end

endmodule

// ==== rtl/fetchStage.sv ====
`timescale 1ns/10ps

module fetchStage (
	input  logic                          CLK,
	input  logic                          rstN,
	input  logic                          stall,
	output logic [mipsPkg::dataWidth-1:0] instrAddress,
	input  mipsPkg::instrWord             instrData,
	output mipsPkg::fetchPkt              fetchOut
);

	logic [mipsPkg::dataWidth-1:0] pc;
	logic [mipsPkg::dataWidth-1:0] pcNext;

	// instruction memory answers in the same cycle
	assign instrAddress = pc;
	assign pcNext       = pc + 32'd4;

	// ----------------------------------------
	// pc and fetch register
	// ----------------------------------------
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			pc       <= '0;
			fetchOut <= '0;
		end else if (!stall) begin
			pc             <= pcNext;
			fetchOut.valid <= 1'b1;
			fetchOut.pc    <= pc;
			fetchOut.instr <= instrData; // word sampled with its own pc
		end
		// stalled, pc and fetched word both hold
	end

endmodule

// ==== rtl/mipsPkg.sv ====
package mipsPkg;

	localparam int dataWidth    = 32;
	localparam int regAddrWidth = 5;
	localparam int regCount     = 1 << regAddrWidth;

	// ----------------------------------------
	// opcodes and function codes
	// ----------------------------------------
	localparam logic [5:0] opSpecial = 6'h00; // R-type, op picked by funct
	localparam logic [5:0] opAddiu   = 6'h09;
	localparam logic [5:0] opAndi    = 6'h0c;
	localparam logic [5:0] opOri     = 6'h0d;
	localparam logic [5:0] opLui     = 6'h0f;
	localparam logic [5:0] opLw      = 6'h23;
	localparam logic [5:0] opSb      = 6'h28;
	localparam logic [5:0] opSh      = 6'h29;
	localparam logic [5:0] opSw      = 6'h2b;

	localparam logic [5:0] fnSll  = 6'h00;
	localparam logic [5:0] fnSrl  = 6'h02;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnXor  = 6'h26;
	localparam logic [5:0] fnSlt  = 6'h2a;

	// bytes written per store, a full word wraps to 0
	localparam logic [1:0] sizeByte = 2'd1;
	localparam logic [1:0] sizeHalf = 2'd2;
	localparam logic [1:0] sizeWord = 2'd0;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluSll,
		aluSrl,
		aluLui // passes the upper-extended immediate
	} aluOp;

	// ----------------------------------------
	// instruction word views
	// ----------------------------------------
	typedef struct packed {
		logic [5:0]              opcode;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [regAddrWidth-1:0] rd;
		logic [4:0]              shamt;
		logic [5:0]              funct;
	} rFields;

	typedef struct packed {
		logic [5:0]              opcode;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [15:0]             imm;
	} iFields;

	typedef union packed {
		rFields rType;
		iFields iType;
	} instrWord;

	// ----------------------------------------
	// stage packets
	// ----------------------------------------
	typedef struct packed {
		logic                 valid;
		logic [dataWidth-1:0] pc;
		instrWord             instr;
	} fetchPkt;

	typedef struct packed {
		logic                    valid;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [regAddrWidth-1:0] dest;
		logic                    regWrite;
		aluOp                    aluCtrl;
		logic                    useImm;
		logic [dataWidth-1:0]    immediate; // already extended
		logic [4:0]              shamt;
		logic                    memRead;
		logic                    memWrite;
		logic [1:0]              writeSize;
	} ctrlPkt;

	typedef struct packed {
		logic                    valid;
		logic [regAddrWidth-1:0] dest;
		logic                    regWrite;
		aluOp                    aluCtrl;
		logic                    useImm;
		logic [dataWidth-1:0]    immediate;
		logic [4:0]              shamt;
		logic                    memRead;
		logic                    memWrite;
		logic [1:0]              writeSize;
		logic [dataWidth-1:0]    operandA; // rs value
		logic [dataWidth-1:0]    operandB; // rt value
	} operandPkt;

	typedef struct packed {
		logic                    valid;
		logic [regAddrWidth-1:0] dest;
		logic                    regWrite;
		logic                    memRead;
		logic                    memWrite;
		logic [1:0]              writeSize;
		logic [dataWidth-1:0]    result; // alu value or address
		logic [dataWidth-1:0]    storeData;
	} execPkt;

	typedef struct packed {
		logic                    valid;
		logic [regAddrWidth-1:0] dest;
		logic [dataWidth-1:0]    data;
	} wbPkt;

endpackage
